//--- design/rift_pkg.sv
// Shared core definitions. RV32I subset only, and any encoding outside the subset decodes as NOP.
package rift_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5; // Register index width.
	localparam logic [XLEN-1:0] RESET_PC = '0;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Unprivileged, secure, instruction access.
	localparam logic [2:0] AXI_PROT_INSTR = 3'b100;

	// RV32I major opcodes of the kept subset.
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000; // Selects SUB.

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_LUI,
		OP_JAL,
		OP_BEQ,
		OP_BNE
	} op_e;

	// Decoded instruction as it travels through the queue.
	typedef struct packed {
		logic [XLEN-1:0]   pc;
		op_e               op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0]   imm;  // Already sign extended.
		logic [XLEN-1:0]   link; // Return address, pc + 4.
	} micro_instr_t;

endpackage

//--- design/instr_queue_if.sv
// Queue handshake. The producer must not push while reject is high, and pop_instr is only valid while empty is low.
`timescale 1ns/1ps

interface instr_queue_if #(
	parameter type payload_t = logic
);

	logic     push;
	payload_t push_instr;
	logic     reject; // Queue full.
	logic     pop;
	payload_t pop_instr;
	logic     empty;

	modport producer (output push, output push_instr, input reject);

	modport queue (
		input  push, push_instr, pop,
		output reject, pop_instr, empty
	);

	modport consumer (output pop, input pop_instr, input empty);

endinterface

//--- design/instr_fifo.sv
// Instruction queue of QUEUE_DEPTH entries. Flush drops everything, including a push in the same cycle.
`timescale 1ns/1ps

module instr_fifo #(
	parameter type payload_t = logic
) (
	instr_queue_if.queue queue,

	input logic flush,
	input logic CLK,
	input logic reset
);

	payload_t mem [rift_pkg::QUEUE_DEPTH];

	logic [rift_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [rift_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [rift_pkg::QUEUE_CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign queue.reject = (count == rift_pkg::QUEUE_CNT_W'(rift_pkg::QUEUE_DEPTH));
	assign queue.empty = (count == '0);
	assign queue.pop_instr = mem[rd_ptr];

	assign do_push = queue.push & ~queue.reject; // Guard against a push while full.
	assign do_pop = queue.pop & ~queue.empty;

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == rift_pkg::QUEUE_PTR_W'(rift_pkg::QUEUE_DEPTH - 1)) ?
					'0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == rift_pkg::QUEUE_PTR_W'(rift_pkg::QUEUE_DEPTH - 1)) ?
					'0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;
		end
	end

	// Storage.
	always_ff @(posedge CLK) begin
		if (do_push && !flush) mem[wr_ptr] <= queue.push_instr;
	end

endmodule

//--- design/instr_decode.sv
// Purely combinational decoder for ADDI, ADD, SUB, AND, OR, XOR, LUI, JAL, BEQ and BNE. Anything else is a NOP with rd zero.
`timescale 1ns/1ps

module instr_decode (
	input  logic [rift_pkg::XLEN-1:0] instr,
	input  logic [rift_pkg::XLEN-1:0] pc,
	output rift_pkg::micro_instr_t micro_instr
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rift_pkg::XLEN-1:0] imm_i;
	logic [rift_pkg::XLEN-1:0] imm_u;
	logic [rift_pkg::XLEN-1:0] imm_b;
	logic [rift_pkg::XLEN-1:0] imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		micro_instr.pc = pc;
		micro_instr.link = pc + 32'd4;
		micro_instr.op = rift_pkg::OP_NOP;
		micro_instr.rd = '0;
		micro_instr.rs1 = instr[19:15];
		micro_instr.rs2 = instr[24:20];
		micro_instr.imm = '0;

		case (opcode)
			rift_pkg::OPC_OP_IMM: begin
				if (funct3 == rift_pkg::F3_ADD_SUB) micro_instr.op = rift_pkg::OP_ADDI;
				micro_instr.imm = imm_i;
			end
			rift_pkg::OPC_OP: begin
				if (funct7 == rift_pkg::F7_BASE) begin
					case (funct3)
						rift_pkg::F3_ADD_SUB: micro_instr.op = rift_pkg::OP_ADD;
						rift_pkg::F3_XOR:     micro_instr.op = rift_pkg::OP_XOR;
						rift_pkg::F3_OR:      micro_instr.op = rift_pkg::OP_OR;
						rift_pkg::F3_AND:     micro_instr.op = rift_pkg::OP_AND;
						default:              micro_instr.op = rift_pkg::OP_NOP;
					endcase
				end else if (funct7 == rift_pkg::F7_ALT && funct3 == rift_pkg::F3_ADD_SUB) begin
					micro_instr.op = rift_pkg::OP_SUB;
				end
			end
			rift_pkg::OPC_LUI: begin
				micro_instr.op = rift_pkg::OP_LUI;
				micro_instr.imm = imm_u;
			end
			rift_pkg::OPC_JAL: begin
				micro_instr.op = rift_pkg::OP_JAL;
				micro_instr.imm = imm_j;
			end
			rift_pkg::OPC_BRANCH: begin
				if (funct3 == rift_pkg::F3_BEQ) micro_instr.op = rift_pkg::OP_BEQ;
				else if (funct3 == rift_pkg::F3_BNE) micro_instr.op = rift_pkg::OP_BNE;
				micro_instr.imm = imm_b;
			end
			default: micro_instr.op = rift_pkg::OP_NOP;
		endcase

		// Only register writers carry a destination.
		if (micro_instr.op != rift_pkg::OP_NOP && micro_instr.op != rift_pkg::OP_BEQ &&
			micro_instr.op != rift_pkg::OP_BNE) begin
			micro_instr.rd = instr[11:7];
		end
	end

endmodule

//--- design/fetch_unit.sv
// Single outstanding AXI4-Lite read and no prediction beyond JAL. ifu_rresp is ignored, so every beat is taken as OKAY.
`timescale 1ns/1ps

module fetch_unit (
	output logic [rift_pkg::XLEN-1:0] ifu_araddr,
	output logic [2:0] ifu_arprot,
	output logic ifu_arvalid,
	input  logic ifu_arready,
	input  logic [rift_pkg::XLEN-1:0] ifu_rdata,
	input  logic [1:0] ifu_rresp,
	input  logic ifu_rvalid,
	output logic ifu_rready,

	instr_queue_if.producer queue,

	input logic [rift_pkg::XLEN-1:0] redirect_pc,
	input logic flush,
	input logic CLK,
	input logic reset
);

	logic [rift_pkg::XLEN-1:0] pc_q;      // Address of the next read.
	logic r_wait_q;                       // Address accepted, data pending.
	logic stale_q;                        // In-flight read belongs to the old path.
	logic beat_valid_q;
	logic [rift_pkg::XLEN-1:0] beat_q;
	logic [rift_pkg::XLEN-1:0] beat_pc_q;

	rift_pkg::micro_instr_t decoded;
	logic [rift_pkg::XLEN-1:0] next_pc;
	logic [rift_pkg::XLEN-1:0] fetch_addr;
	logic r_done;
	logic issue;

	instr_decode i_instr_decode (
		.instr(beat_q),
		.pc(beat_pc_q),
		.micro_instr(decoded)
	);

	assign ifu_arprot = rift_pkg::AXI_PROT_INSTR;
	assign ifu_rready = r_wait_q;
	assign r_done = r_wait_q & ifu_rvalid;

	// A held beat waits here while the queue is full.
	assign queue.push = beat_valid_q & ~queue.reject & ~flush;
	assign queue.push_instr = decoded;

	// JAL is redirected here, everything else falls through.
	assign next_pc = (decoded.op == rift_pkg::OP_JAL) ? decoded.pc + decoded.imm : decoded.link;

	// Start the next read as soon as the last beat leaves, unless back-pressured.
	assign issue = ~ifu_arvalid & ~r_wait_q & (~beat_valid_q | queue.push) &
		~queue.reject & ~flush;
	assign fetch_addr = queue.push ? next_pc : pc_q;

	always_ff @(posedge CLK) begin
		if (reset) begin
			ifu_arvalid <= 1'b0;
			r_wait_q <= 1'b0;
			stale_q <= 1'b0;
			beat_valid_q <= 1'b0;
			pc_q <= rift_pkg::RESET_PC;
		end else begin
			if (issue) ifu_arvalid <= 1'b1;
			else if (ifu_arready) ifu_arvalid <= 1'b0;

			if (ifu_arvalid && ifu_arready) r_wait_q <= 1'b1;
			else if (r_done) r_wait_q <= 1'b0;

			if (r_done) stale_q <= 1'b0;
			else if (flush && (ifu_arvalid || r_wait_q)) stale_q <= 1'b1;

			if (flush) beat_valid_q <= 1'b0; // Also drops a beat landing this cycle.
			else if (r_done && !stale_q) beat_valid_q <= 1'b1;
			else if (queue.push) beat_valid_q <= 1'b0;

			if (flush) pc_q <= redirect_pc;
			else if (queue.push) pc_q <= next_pc;
		end
	end

	// Address and data registers.
	always_ff @(posedge CLK) begin
		if (issue) ifu_araddr <= fetch_addr; // Stable until the handshake.
		if (r_done) begin
			beat_q <= ifu_rdata;
			beat_pc_q <= ifu_araddr;
		end
	end

endmodule

//--- design/exec_unit.sv
// One micro-instruction per cycle with no forwarding hazards. Register file clears to zero on reset and x0 is hardwired.
`timescale 1ns/1ps

module exec_unit (
	instr_queue_if.consumer queue,

	output logic redirect_valid,
	output logic [rift_pkg::XLEN-1:0] redirect_pc,

	output logic retire_valid,
	output logic [rift_pkg::XLEN-1:0] retire_pc,
	output logic [rift_pkg::REG_AW-1:0] retire_rd,
	output logic [rift_pkg::XLEN-1:0] retire_wdata,

	input logic CLK,
	input logic reset
);

	logic [rift_pkg::XLEN-1:0] regs [2**rift_pkg::REG_AW];

	rift_pkg::micro_instr_t mi;
	logic pop;
	logic [rift_pkg::XLEN-1:0] rs1_val;
	logic [rift_pkg::XLEN-1:0] rs2_val;
	logic [rift_pkg::XLEN-1:0] result;
	logic wen;
	logic taken;

	assign mi = queue.pop_instr;

	// Hold off for a cycle while the redirect is in flight.
	assign pop = ~queue.empty & ~redirect_valid;
	assign queue.pop = pop;

	assign rs1_val = (mi.rs1 == '0) ? '0 : regs[mi.rs1];
	assign rs2_val = (mi.rs2 == '0) ? '0 : regs[mi.rs2];

	always_comb begin
		result = '0;
		wen = 1'b1;
		taken = 1'b0;

		case (mi.op)
			rift_pkg::OP_ADD:  result = rs1_val + rs2_val;
			rift_pkg::OP_SUB:  result = rs1_val - rs2_val;
			rift_pkg::OP_AND:  result = rs1_val & rs2_val;
			rift_pkg::OP_OR:   result = rs1_val | rs2_val;
			rift_pkg::OP_XOR:  result = rs1_val ^ rs2_val;
			rift_pkg::OP_ADDI: result = rs1_val + mi.imm;
			rift_pkg::OP_LUI:  result = mi.imm;
			rift_pkg::OP_JAL:  result = mi.link; // Target was already taken in fetch.
			rift_pkg::OP_BEQ: begin
				wen = 1'b0;
				taken = (rs1_val == rs2_val);
			end
			rift_pkg::OP_BNE: begin
				wen = 1'b0;
				taken = (rs1_val != rs2_val);
			end
			default: wen = 1'b0;
		endcase

		if (mi.rd == '0) wen = 1'b0; // Writes to x0 are dropped.
	end

	// Retirement is reported in the pop cycle.
	assign retire_valid = pop;
	assign retire_pc = mi.pc;
	assign retire_rd = wen ? mi.rd : '0;
	assign retire_wdata = wen ? result : '0;

	// Branches are predicted not taken, so a taken one costs a redirect.
	always_ff @(posedge CLK) begin
		if (reset) redirect_valid <= 1'b0;
		else redirect_valid <= pop & taken;
	end

	always_ff @(posedge CLK) begin
		if (pop && taken) redirect_pc <= mi.pc + mi.imm;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 2**rift_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (pop && wen) begin
			regs[mi.rd] <= result;
		end
	end

endmodule

//--- design/rift_core.sv
// Core top level with instruction fetch over AXI4-Lite read only. There are no loads, stores or interrupts, and ifu_rresp is not checked.
`timescale 1ns/1ps

module rift_core (
	output logic [rift_pkg::XLEN-1:0] ifu_araddr,
	output logic [2:0] ifu_arprot,
	output logic ifu_arvalid,
	input  logic ifu_arready,
	input  logic [rift_pkg::XLEN-1:0] ifu_rdata,
	input  logic [1:0] ifu_rresp,
	input  logic ifu_rvalid,
	output logic ifu_rready,

	output logic retire_valid,
	output logic [rift_pkg::XLEN-1:0] retire_pc,
	output logic [rift_pkg::REG_AW-1:0] retire_rd,
	output logic [rift_pkg::XLEN-1:0] retire_wdata,

	input logic CLK,
	input logic reset
);

	logic redirect_valid;
	logic [rift_pkg::XLEN-1:0] redirect_pc;
	logic mispredict_q;
	logic queue_flush;

	instr_queue_if #(.payload_t(rift_pkg::micro_instr_t)) iq ();

	// Set by the redirect, cleared by the first fetch on the new path.
	always_ff @(posedge CLK) begin
		if (reset) mispredict_q <= 1'b0;
		else if (redirect_valid) mispredict_q <= 1'b1;
		else if (iq.push) mispredict_q <= 1'b0;
	end

	// Queue stays clear while the flag is up, so the back end sees it as empty.
	assign queue_flush = redirect_valid | (mispredict_q & ~iq.push);

	fetch_unit i_fetch_unit (
		.ifu_araddr(ifu_araddr),
		.ifu_arprot(ifu_arprot),
		.ifu_arvalid(ifu_arvalid),
		.ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata),
		.ifu_rresp(ifu_rresp),
		.ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.queue(iq.producer),
		.redirect_pc(redirect_pc),
		.flush(redirect_valid),
		.CLK(CLK),
		.reset(reset)
	);

	instr_fifo #(.payload_t(rift_pkg::micro_instr_t)) i_instr_fifo (
		.queue(iq.queue),
		.flush(queue_flush),
		.CLK(CLK),
		.reset(reset)
	);

	exec_unit i_exec_unit (
		.queue(iq.consumer),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata),
		.CLK(CLK),
		.reset(reset)
	);

endmodule

//--- testbench/rift_core_checker.sv
// ISA model of the subset from RESET_PC. The reset state is sampled on the falling edge.
`timescale 1ns/1ps

module rift_core_checker #(
	parameter int PROG_WORDS = 200
) (
	input logic CLK,
	input logic reset,
	input logic ifu_arvalid,
	input logic [31:0] ifu_araddr,
	input logic [2:0] ifu_arprot,
	input logic ifu_rvalid,
	input logic ifu_rready,
	input logic retire_valid,
	input logic [31:0] retire_pc,
	input logic [4:0] retire_rd,
	input logic [31:0] retire_wdata,
	input logic [PROG_WORDS*32-1:0] program_image,
	input logic timed_out,
	output int error_total,
	output logic finished
);

	logic [31:0] model_regs [32];
	logic [31:0] model_pc = rift_pkg::RESET_PC;
	logic model_done = 1'b0;
	logic first_fetch_seen = 1'b0;
	int retired = 0;
	int pc_errors = 0;
	int rd_errors = 0;
	int data_errors = 0;
	int reset_errors = 0;
	int axi_errors = 0;

	function automatic int report_mismatch(string test, string field, logic [31:0] expected,
		logic [31:0] actual);
		if (expected === actual) return 0;
		$display("** Error [%s] %s: expected %h, actual %h at %0t ns", test, field, expected,
			actual, $time);
		return 1;
	endfunction

	// Executes the model's next instruction and compares it with the retire port.
	task automatic retire_one();
		logic [31:0] w;
		logic [31:0] rs1_v;
		logic [31:0] rs2_v;
		logic [31:0] next_pc;
		logic [31:0] exp_wdata;
		logic [4:0] exp_rd;
		logic has_write;
		string test;
		w = program_image[model_pc[31:2]*32 +: 32];
		rs1_v = model_regs[w[19:15]];
		rs2_v = model_regs[w[24:20]];
		next_pc = model_pc + 32'd4;
		exp_wdata = '0;
		exp_rd = w[11:7];
		has_write = 1'b1;
		test = "alu_lui";
		case (w[6:0])
			7'b0010011: begin // Only ADDI is kept from OP-IMM.
				if (w[14:12] == 3'b000) exp_wdata = rs1_v + {{20{w[31]}}, w[31:20]};
				else has_write = 1'b0;
			end
			7'b0110011: begin
				case ({w[31:25], w[14:12]})
					10'b0000000_000: exp_wdata = rs1_v + rs2_v;
					10'b0100000_000: exp_wdata = rs1_v - rs2_v;
					10'b0000000_111: exp_wdata = rs1_v & rs2_v;
					10'b0000000_110: exp_wdata = rs1_v | rs2_v;
					10'b0000000_100: exp_wdata = rs1_v ^ rs2_v;
					default: has_write = 1'b0;
				endcase
			end
			7'b0110111: exp_wdata = {w[31:12], 12'b0};
			7'b1101111: begin
				test = "jal";
				exp_wdata = model_pc + 32'd4;
				next_pc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			7'b1100011: begin
				test = "branch";
				has_write = 1'b0;
				if ((w[14:12] == 3'b000 && rs1_v == rs2_v) ||
					(w[14:12] == 3'b001 && rs1_v != rs2_v)) begin
					next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			default: has_write = 1'b0;
		endcase
		if (!has_write || exp_rd == 5'd0) begin
			exp_rd = 5'd0;
			if (test == "alu_lui") test = "x0_nop";
		end
		pc_errors += report_mismatch(test, "retire_pc", model_pc, retire_pc);
		rd_errors += report_mismatch(test, "retire_rd", {27'b0, exp_rd}, {27'b0, retire_rd});
		if (exp_rd != 5'd0) begin
			data_errors += report_mismatch(test, "retire_wdata", exp_wdata, retire_wdata);
			model_regs[exp_rd] = exp_wdata;
		end
		retired++;
		if (next_pc == model_pc) model_done = 1'b1; // Final self-loop reached.
		model_pc = next_pc;
	endtask

	initial begin
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
	end

	always @(posedge CLK) begin
		if (!reset && retire_valid === 1'b1 && !model_done) retire_one();
	end

	// Every data beat meets ifu_rready and every address is an instruction access.
	always @(posedge CLK) begin
		if (!reset && ifu_rvalid === 1'b1) begin
			axi_errors += report_mismatch("axi_read", "ifu_rready", 32'd1, {31'b0, ifu_rready});
		end
		if (!reset && ifu_arvalid === 1'b1) begin
			axi_errors += report_mismatch("axi_read", "ifu_arprot[2]", 32'd1,
				{31'b0, ifu_arprot[2]});
		end
	end

	// Reset state and the first fetch address.
	always @(negedge CLK) begin
		if (reset) begin
			reset_errors += report_mismatch("reset_state", "ifu_arvalid", 32'd0,
				{31'b0, ifu_arvalid});
			reset_errors += report_mismatch("reset_state", "retire_valid", 32'd0,
				{31'b0, retire_valid});
		end else if (ifu_arvalid === 1'b1 && !first_fetch_seen) begin
			reset_errors += report_mismatch("reset_state", "first ifu_araddr",
				rift_pkg::RESET_PC, ifu_araddr);
			first_fetch_seen = 1'b1;
		end
	end

	initial begin
		finished = 1'b0;
		wait (model_done || timed_out);
		error_total = pc_errors + rd_errors + data_errors + reset_errors + axi_errors;
		$display("Retired %0d, errors pc %0d rd %0d data %0d reset %0d axi %0d total %0d",
			retired, pc_errors, rd_errors, data_errors, reset_errors, axi_errors,
			error_total);
		finished <= 1'b1;
	end

endmodule

//--- testbench/rift_core_tb.sv
// Random program from a fixed seed. The AXI responder serves only it and always answers OKAY.
`timescale 1ns/1ps

module rift_core_tb #(
	parameter int PROG_WORDS = 200,
	parameter int CLK_PERIOD = 100
);

	logic CLK;
	logic reset;
	logic [31:0] ifu_araddr;
	logic [2:0] ifu_arprot;
	logic ifu_arvalid;
	logic ifu_arready;
	logic [31:0] ifu_rdata;
	logic [1:0] ifu_rresp;
	logic ifu_rvalid;
	logic ifu_rready;
	logic retire_valid;
	logic [31:0] retire_pc;
	logic [4:0] retire_rd;
	logic [31:0] retire_wdata;

	logic [PROG_WORDS*32-1:0] program_image;
	logic timed_out;
	logic finished;
	int error_total;
	int ar_count;  // Cycles left before ifu_arready. Negative while idle.
	int r_count;   // Cycles left before ifu_rvalid. Negative while idle.
	logic [31:0] r_addr;

	rift_core UUT (
		.ifu_araddr(ifu_araddr),
		.ifu_arprot(ifu_arprot),
		.ifu_arvalid(ifu_arvalid),
		.ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata),
		.ifu_rresp(ifu_rresp),
		.ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata),
		.CLK(CLK),
		.reset(reset)
	);

	rift_core_checker #(.PROG_WORDS(PROG_WORDS)) retire_checker (
		.CLK(CLK),
		.reset(reset),
		.ifu_arvalid(ifu_arvalid),
		.ifu_araddr(ifu_araddr),
		.ifu_arprot(ifu_arprot),
		.ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata),
		.program_image(program_image),
		.timed_out(timed_out),
		.error_total(error_total),
		.finished(finished)
	);

	function automatic logic [31:0] encode_r(logic [6:0] funct7, logic [2:0] funct3,
		logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encode_b(int offset, logic [2:0] funct3,
		logic [4:0] rs1, logic [4:0] rs2);
		logic [12:0] imm;
		imm = 13'(offset);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encode_j(int offset, logic [4:0] rd);
		logic [20:0] imm;
		imm = 21'(offset);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] program_word(logic [31:0] addr);
		if (addr[31:2] < PROG_WORDS) return program_image[addr[31:2]*32 +: 32];
		return 32'h0000_0013; // ADDI x0, x0, 0 outside the program.
	endfunction

	// Forward-only branches and jumps, so every path ends in the last word.
	task automatic build_program();
		logic [31:0] word;
		logic [31:0] raw;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		int kind;
		int target;
		for (int i = 0; i < PROG_WORDS - 1; i++) begin
			kind = $urandom_range(11, 0);
			rd = 5'($urandom_range(7, 0)); // Few registers, so operands often match.
			rs1 = 5'($urandom_range(7, 0));
			rs2 = 5'($urandom_range(7, 0));
			raw = $urandom;
			target = i + $urandom_range(8, 1);
			if (target > PROG_WORDS - 1) target = PROG_WORDS - 1;
			case (kind)
				0, 11: word = {raw[11:0], rs1, 3'b000, rd, 7'b0010011}; // ADDI.
				1: word = encode_r(7'b0000000, 3'b000, rd, rs1, rs2);
				2: word = encode_r(7'b0100000, 3'b000, rd, rs1, rs2);
				3: word = encode_r(7'b0000000, 3'b111, rd, rs1, rs2);
				4: word = encode_r(7'b0000000, 3'b110, rd, rs1, rs2);
				5: word = encode_r(7'b0000000, 3'b100, rd, rs1, rs2);
				6: word = {raw[31:12], rd, 7'b0110111}; // LUI.
				7: word = encode_j((target - i) * 4, rd);
				8: word = encode_b((target - i) * 4, 3'b000, rs1, rs2);
				9: word = encode_b((target - i) * 4, 3'b001, rs1, rs2);
				default: word = {raw[31:7], 7'b0001011}; // Custom-0 is undefined in this core.
			endcase
			program_image[i*32 +: 32] = word;
		end
		program_image[(PROG_WORDS-1)*32 +: 32] = encode_j(0, 5'd0); // Final self-loop.
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		void'($urandom(32'hee14));
		reset = 1'b1;
		ifu_arready = 1'b0;
		ifu_rvalid = 1'b0;
		ifu_rdata = '0;
		ifu_rresp = 2'b00;
		build_program();
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		reset <= 1'b0;
	end

	// AXI4-Lite read responder with 0 to 3 cycles of delay on each channel.
	always @(negedge CLK) begin
		if (reset) begin
			ifu_arready <= 1'b0;
			ifu_rvalid <= 1'b0;
			ar_count = -1;
			r_count = -1;
		end else begin
			if (ifu_rvalid) ifu_rvalid <= 1'b0; // ifu_rready is up while a read is pending.
			if (ifu_arready) begin
				ifu_arready <= 1'b0; // Address was taken on the last rising edge.
				r_count = $urandom_range(3, 0);
			end else if (ifu_arvalid) begin
				if (ar_count < 0) ar_count = $urandom_range(3, 0);
				if (ar_count == 0) begin
					ifu_arready <= 1'b1;
					r_addr = ifu_araddr;
					ar_count = -1;
				end else begin
					ar_count--;
				end
			end
			if (r_count == 0) begin
				ifu_rvalid <= 1'b1;
				ifu_rdata <= program_word(r_addr);
				r_count = -1;
			end else if (r_count > 0) begin
				r_count--;
			end
		end
	end

	initial begin
		timed_out = 1'b0;
		#((PROG_WORDS * 10 + 3) * CLK_PERIOD);
		$display("Watchdog: the core did not reach the final loop within %0d ns, it hangs",
			(PROG_WORDS * 10 + 3) * CLK_PERIOD);
		timed_out = 1'b1;
	end

	initial begin
		wait (finished === 1'b1);
		if (timed_out || error_total != 0) begin
			$display("tests failed");
		end else begin
			$display("all tests passed");
		end
		$finish;
	end

endmodule

//--- rift_core.f
design/rift_pkg.sv
design/instr_queue_if.sv
design/instr_fifo.sv
design/instr_decode.sv
design/fetch_unit.sv
design/exec_unit.sv
design/rift_core.sv
testbench/rift_core_checker.sv
testbench/rift_core_tb.sv

//--- Bender.yml
package:
  name: rift_core

sources:
  - files:
      - design/rift_pkg.sv
      - design/instr_queue_if.sv
      - design/instr_fifo.sv
      - design/instr_decode.sv
      - design/fetch_unit.sv
      - design/exec_unit.sv
      - design/rift_core.sv
  - target: test
    files:
      - testbench/rift_core_checker.sv
      - testbench/rift_core_tb.sv
